//--- axis_clock_width_conv.f
rtl/axis_stream_pkg.sv
rtl/axis_dw_pkg.sv
rtl/axis_async_fifo.sv
rtl/axis_downsizer.sv
rtl/axis_clock_width_conv.sv
testbench/axis_clock_width_conv_sva.sv
testbench/axis_clock_width_conv_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= axis_clock_width_conv_tb
FLIST     ?= axis_clock_width_conv.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# the run fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/axis_clock_width_conv_tb.sv
`default_nettype none
`timescale 1ns/1ns

// directed tests for the clk_a to clk_b stream converter
module axis_clock_width_conv_tb import axis_stream_pkg::*; ();

  // limits in clk_a cycles
  localparam int TIMEOUT = 400;
  localparam int SETTLE  = 48;
  localparam int QUIET   = 20;

  typedef enum logic [1:0] {
    READY_HIGH,
    READY_LOW,
    READY_RAND
  } ready_mode_t;

  logic               clk_a = 1'b0;
  logic               clk_b = 1'b0;
  logic               i_reset;
  logic               i_s_valid;
  logic               o_s_ready;
  logic [WIDTH_S-1:0] i_s_data;
  logic               o_m_valid;
  logic               i_m_ready = 1'b0;
  logic [WIDTH_M-1:0] o_m_data;

  // expected bytes, the clk_b monitor walks it with rd_idx
  logic [WIDTH_M-1:0] exp_q[$];
  int                 rd_idx = 0;
  int                 words_in = 0;
  int                 beat_count = 0;
  int                 mon_checks = 0;
  int                 mon_errs = 0;
  int                 check_count;
  int                 err_count;
  logic [31:0]        lcg_state;
  ready_mode_t        ready_mode;
  // sink stall pattern, filled from the LCG before the tests
  logic [63:0]        stall_pat;
  logic [5:0]         stall_idx = '0;

  always #2 clk_a = ~clk_a;
  always #1 clk_b = ~clk_b;

  axis_clock_width_conv dut0 (
    .clk_a     (clk_a),
    .clk_b     (clk_b),
    .i_reset   (i_reset),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .i_s_data  (i_s_data),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .o_m_data  (o_m_data)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int errors_so_far();
    return err_count + mon_errs;
  endfunction

  // sink ready on clk_b
  always @(posedge clk_b) begin
    if (ready_mode == READY_HIGH) begin
      i_m_ready <= 1'b1;
    end else if (ready_mode == READY_LOW) begin
      i_m_ready <= 1'b0;
    end else begin
      i_m_ready <= stall_pat[stall_idx];
      stall_idx <= stall_idx + 6'd1;
    end
  end

  // each accepted word gives its low byte first, then its high byte
  always @(posedge clk_a) begin
    if (i_s_valid && o_s_ready) begin
      exp_q.push_back(i_s_data[WIDTH_M-1:0]);
      exp_q.push_back(i_s_data[WIDTH_S-1:WIDTH_M]);
      words_in++;
    end
  end

  // compare every master handshake with the next expected byte
  always @(posedge clk_b) begin
    if (o_m_valid && i_m_ready) begin
      mon_checks++;
      if (rd_idx >= exp_q.size()) begin
        $display("output byte %h arrived with nothing expected", o_m_data);
        mon_errs++;
      end else begin
        assert (o_m_data === exp_q[rd_idx]) else begin
          $display("mismatch o_m_data expected %h got %h", exp_q[rd_idx], o_m_data);
          mon_errs++;
        end
      end
      rd_idx++;
      beat_count++;
    end
  end

  task automatic report_timeout(input string what);
    $display("timeout: %s", what);
    err_count++;
  endtask

  task automatic compare_count(input string name, input int expected, input int actual);
    check_count++;
    assert (actual == expected) else begin
      $display("mismatch %s expected %h got %h", name, expected, actual);
      err_count++;
    end
  endtask

  task automatic compare_bit(input string name, input logic expected, input logic actual);
    check_count++;
    assert (actual === expected) else begin
      $display("mismatch %s expected %h got %h", name, expected, actual);
      err_count++;
    end
  endtask

  task automatic print_result(input string name, input int errs_before);
    if (errors_so_far() == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors_so_far() - errs_before);
    end
  endtask

  // called just after a clk_a edge, o_s_ready still shows its pre-edge value
  task automatic wait_s_ready(input string what);
    int waited;
    waited = 0;
    while (o_s_ready !== 1'b1 && waited < TIMEOUT) begin
      @(posedge clk_a);
      waited++;
    end
    if (o_s_ready !== 1'b1) begin
      report_timeout(what);
    end
  endtask

  // returns on the handshake edge, so the next word can follow at once
  task automatic push_word(input logic [WIDTH_S-1:0] data);
    i_s_valid <= 1'b1;
    i_s_data  <= data;
    @(posedge clk_a);
    wait_s_ready("slave handshake never completed");
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(posedge clk_a);
    while (exp_q.size() != rd_idx && waited < TIMEOUT) begin
      @(posedge clk_a);
      waited++;
    end
    if (exp_q.size() != rd_idx) begin
      report_timeout("expected bytes never left the master port");
    end
  endtask

  // nothing is pending, so no master beat may show up
  task automatic expect_idle();
    for (int cyc = 0; cyc < QUIET; cyc++) begin
      @(posedge clk_a);
      compare_bit("o_m_valid", 1'b0, o_m_valid);
    end
  endtask

  task automatic check_reset_state();
    int errs_before;
    errs_before = errors_so_far();
    for (int cyc = 1; cyc <= 16; cyc++) begin
      @(posedge clk_a);
      // first edges still clear the flops
      if (cyc > 4) begin
        compare_bit("o_s_ready", 1'b0, o_s_ready);
        compare_bit("o_m_valid", 1'b0, o_m_valid);
      end
    end
    i_reset <= 1'b0;
    // first edge with i_reset low raises ready, seen at the edge after it
    @(posedge clk_a);
    compare_bit("o_s_ready", 1'b0, o_s_ready);
    @(posedge clk_a);
    compare_bit("o_s_ready", 1'b1, o_s_ready);
    compare_bit("o_m_valid", 1'b0, o_m_valid);
    print_result("reset_state", errs_before);
  endtask

  task automatic split_single_word();
    int errs_before;
    int beats_before;
    errs_before  = errors_so_far();
    beats_before = beat_count;
    ready_mode   = READY_HIGH;
    push_word(16'h0b0c);
    i_s_valid <= 1'b0;
    wait_drain();
    // nothing may follow the two bytes
    expect_idle();
    compare_count("beat_count", 2, beat_count - beats_before);
    print_result("single_word", errs_before);
  endtask

  task automatic stream_burst();
    int          errs_before;
    int          beats_before;
    logic [31:0] rnd;
    errs_before  = errors_so_far();
    beats_before = beat_count;
    for (int w = 0; w < 40; w++) begin
      rnd = lcg_next();
      push_word(rnd[31:16]);
    end
    i_s_valid <= 1'b0;
    wait_drain();
    expect_idle();
    compare_count("beat_count", 80, beat_count - beats_before);
    print_result("burst", errs_before);
  endtask

  task automatic fill_under_backpressure();
    int          errs_before;
    int          beats_before;
    int          words_before;
    logic [31:0] rnd;
    errs_before  = errors_so_far();
    beats_before = beat_count;
    ready_mode   = READY_LOW;
    repeat (2) @(posedge clk_a);
    words_before = words_in;
    rnd = lcg_next();
    i_s_valid <= 1'b1;
    i_s_data  <= rnd[31:16];
    // offer words well past the pointer sync delay
    for (int cyc = 0; cyc < SETTLE; cyc++) begin
      @(posedge clk_a);
      if (o_s_ready === 1'b1) begin
        rnd = lcg_next();
        i_s_data <= rnd[31:16];
      end
    end
    // counts move on clk_a, read them between edges
    @(posedge clk_b);
    compare_count("words_in", FIFO_DEPTH + 1, words_in - words_before);
    compare_bit("o_s_ready", 1'b0, o_s_ready);
    @(posedge clk_a);
    ready_mode = READY_HIGH;
    // the word still on offer goes in once space frees up
    wait_s_ready("stalled word never accepted after i_m_ready rose");
    i_s_valid <= 1'b0;
    wait_drain();
    expect_idle();
    compare_count("beat_count", 2 * (FIFO_DEPTH + 2), beat_count - beats_before);
    wait_s_ready("o_s_ready stayed low after the drain");
    print_result("backpressure", errs_before);
  endtask

  task automatic stream_with_stalls();
    int          errs_before;
    int          beats_before;
    logic [31:0] rnd;
    errs_before  = errors_so_far();
    beats_before = beat_count;
    ready_mode   = READY_RAND;
    for (int w = 0; w < 60; w++) begin
      rnd = lcg_next();
      push_word(rnd[31:16]);
      // zero to three idle cycles between words
      if (rnd[13:12] != 2'b00) begin
        i_s_valid <= 1'b0;
        repeat (rnd[13:12]) @(posedge clk_a);
      end
    end
    i_s_valid <= 1'b0;
    ready_mode = READY_HIGH;
    wait_drain();
    expect_idle();
    compare_count("beat_count", 120, beat_count - beats_before);
    compare_count("pending bytes", 0, exp_q.size() - rd_idx);
    print_result("random_stalls", errs_before);
  endtask

  initial begin
    logic [31:0] rnd;
    i_reset     = 1'b1;
    i_s_valid   = 1'b0;
    i_s_data    = '0;
    ready_mode  = READY_LOW;
    check_count = 0;
    err_count   = 0;
    lcg_state   = 32'h9a4a_c64f;
    // sink ready about three cycles in four
    for (int i = 0; i < 64; i++) begin
      rnd = lcg_next();
      stall_pat[i] = (rnd[31:30] != 2'b00);
    end
    check_reset_state();
    split_single_word();
    stream_burst();
    fill_under_backpressure();
    stream_with_stalls();
    $display("checks %0d, errors %0d", check_count + mon_checks, errors_so_far());
    if (errors_so_far() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule : axis_clock_width_conv_tb

`default_nettype wire

//--- testbench/axis_clock_width_conv_sva.sv
`default_nettype none
`timescale 1ns/1ns

// stream protocol checks on the converter ports
module axis_clock_width_conv_sva import axis_stream_pkg::*; (
  input wire logic               clk_a,
  input wire logic               clk_b,
  input wire logic               i_reset,
  input wire logic               i_s_valid,
  input wire logic               o_s_ready,
  input wire logic [WIDTH_S-1:0] i_s_data,
  input wire logic               o_m_valid,
  input wire logic               i_m_ready,
  input wire logic [WIDTH_M-1:0] o_m_data
);

  // master byte stays put until the sink takes it
  m_hold_a: assert property (@(posedge clk_b) disable iff (i_reset)
    o_m_valid && !i_m_ready |=> o_m_valid && $stable(o_m_data))
    else $error("o_m_valid or o_m_data changed before the master handshake");

  // the source side follows the same rule
  s_hold_a: assert property (@(posedge clk_a) disable iff (i_reset)
    i_s_valid && !o_s_ready |=> i_s_valid && $stable(i_s_data))
    else $error("i_s_valid or i_s_data changed before the slave handshake");

  // first reset edge clears the write side, ready is low from then on
  s_reset_a: assert property (@(posedge clk_a)
    i_reset |=> !i_reset || !o_s_ready)
    else $error("o_s_ready high while i_reset is held");

endmodule : axis_clock_width_conv_sva

bind axis_clock_width_conv axis_clock_width_conv_sva sva0 (
  .clk_a     (clk_a),
  .clk_b     (clk_b),
  .i_reset   (i_reset),
  .i_s_valid (i_s_valid),
  .o_s_ready (o_s_ready),
  .i_s_data  (i_s_data),
  .o_m_valid (o_m_valid),
  .i_m_ready (i_m_ready),
  .o_m_data  (o_m_data)
);

`default_nettype wire

//--- rtl/axis_clock_width_conv.sv
`default_nettype none
`timescale 1ns/1ns

// clk_a wide stream in, clk_b narrow stream out
// async FIFO crosses the clocks, the downsizer then splits each word
module axis_clock_width_conv import axis_stream_pkg::*; (
  input  wire logic               clk_a,
  input  wire logic               clk_b,
  input  wire logic               i_reset,
  // slave stream, clk_a
  input  wire logic               i_s_valid,
  output logic                    o_s_ready,
  input  wire logic [WIDTH_S-1:0] i_s_data,
  // master stream, clk_b
  output logic                    o_m_valid,
  input  wire logic               i_m_ready,
  output logic      [WIDTH_M-1:0] o_m_data
);

  // FIFO to downsizer, all on clk_b
  logic               fifo_valid;
  logic               fifo_ready;
  logic [WIDTH_S-1:0] fifo_data;
  // reset after crossing into clk_b
  logic               reset_b;

  axis_async_fifo fifo0 (
    .clk_a     (clk_a),
    .clk_b     (clk_b),
    .i_reset   (i_reset),
    .i_s_valid (i_s_valid),
    .o_s_ready (o_s_ready),
    .i_s_data  (i_s_data),
    .o_m_valid (fifo_valid),
    .i_m_ready (fifo_ready),
    .o_m_data  (fifo_data),
    .o_reset_b (reset_b)
  );

  axis_downsizer dw0 (
    .clk_b     (clk_b),
    .i_reset_b (reset_b),
    .i_s_valid (fifo_valid),
    .o_s_ready (fifo_ready),
    .i_s_data  (fifo_data),
    .o_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .o_m_data  (o_m_data)
  );

endmodule : axis_clock_width_conv

`default_nettype wire

//--- rtl/axis_downsizer.sv
`default_nettype none
`timescale 1ns/1ns

// splits one wide word into RATIO narrow beats
// least significant byte goes out first
module axis_downsizer import axis_stream_pkg::*, axis_dw_pkg::*; (
  input  wire logic               clk_b,
  input  wire logic               i_reset_b,
  // wide stream in
  input  wire logic               i_s_valid,
  output logic                    o_s_ready,
  input  wire logic [WIDTH_S-1:0] i_s_data,
  // narrow stream out
  output logic                    o_m_valid,
  input  wire logic               i_m_ready,
  output logic      [WIDTH_M-1:0] o_m_data
);

  dw_state_t          state_q;
  logic [BEAT_W-1:0]  beat_q;
  logic [WIDTH_S-1:0] word_q;
  logic               last_beat;
  logic               m_xfer;
  logic               s_xfer;

  // valid straight from the state, never from ready
  assign o_m_valid = (state_q == SPLIT);
  assign last_beat = (beat_q == BEAT_W'(RATIO - 1));
  assign m_xfer    = o_m_valid & i_m_ready;

  // take a new word when idle, or in the same edge as the last beat
  // so words stream back to back with no gap
  assign o_s_ready = (state_q == EMPTY) | (m_xfer & last_beat);
  assign s_xfer    = i_s_valid & o_s_ready;

  // byte at the counter, counter starts at the low end
  assign o_m_data = word_q[beat_q * WIDTH_M +: WIDTH_M];

  always_ff @(posedge clk_b) begin
    if (i_reset_b) begin
      state_q <= EMPTY;
      beat_q  <= '0;
    end else if (s_xfer) begin
      // fresh word, restart at beat zero
      state_q <= SPLIT;
      beat_q  <= '0;
    end else if (m_xfer) begin
      beat_q <= beat_q + BEAT_W'(1);
      if (last_beat) begin
        state_q <= EMPTY;
      end
    end
  end

  // held word, loaded on the slave handshake only
  always_ff @(posedge clk_b) begin
    if (s_xfer) begin
      word_q <= i_s_data;
    end
  end

endmodule : axis_downsizer

`default_nettype wire

//--- rtl/axis_async_fifo.sv
`default_nettype none
`timescale 1ns/1ns

// dual clock FIFO with gray coded pointers
// write side on clk_a, first-word-fall-through read side on clk_b
module axis_async_fifo import axis_stream_pkg::*; (
  input  wire logic               clk_a,
  input  wire logic               clk_b,
  input  wire logic               i_reset,
  // write stream, clk_a
  input  wire logic               i_s_valid,
  output logic                    o_s_ready,
  input  wire logic [WIDTH_S-1:0] i_s_data,
  // read stream, clk_b
  output logic                    o_m_valid,
  input  wire logic               i_m_ready,
  output logic      [WIDTH_S-1:0] o_m_data,
  // reset carried into clk_b, for logic downstream
  output logic                    o_reset_b
);

  // binary to gray, one bit changes per increment
  function automatic logic [PTR_W:0] bin2gray(input logic [PTR_W:0] b);
    return (b >> 1) ^ b;
  endfunction

  // gray back to binary, xor down from the top bit
  function automatic logic [PTR_W:0] gray2bin(input logic [PTR_W:0] g);
    logic [PTR_W:0] b;
    b[PTR_W] = g[PTR_W];
    for (int i = PTR_W - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  // storage, written on clk_a only
  logic [WIDTH_S-1:0] mem [FIFO_DEPTH];

  // write domain
  logic [PTR_W:0]                  wr_bin_q;
  logic [PTR_W:0]                  wr_gray_q;
  logic [PTR_W:0]                  wr_bin_nxt;
  logic [SYNC_STAGES-1:0][PTR_W:0] rd_gray_sync_q;
  logic [PTR_W:0]                  rd_bin_sync;
  logic                            wr_live_q;
  logic                            full;
  logic                            wr_push;

  // read domain
  logic [SYNC_STAGES-1:0]          rst_b_sync_q;
  logic                            rd_reset;
  logic [PTR_W:0]                  rd_bin_q;
  logic [PTR_W:0]                  rd_gray_q;
  logic [PTR_W:0]                  rd_bin_nxt;
  logic [SYNC_STAGES-1:0][PTR_W:0] wr_gray_sync_q;
  logic                            empty;
  logic                            rd_pop;

  // write side flags
  // read pointer seen here lags the real one, so full errs on the safe side
  assign rd_bin_sync = gray2bin(rd_gray_sync_q[SYNC_STAGES-1]);
  assign full        = ((wr_bin_q - rd_bin_sync) == (PTR_W + 1)'(FIFO_DEPTH));
  // wr_live_q keeps ready low through reset and up one edge after it
  assign o_s_ready   = wr_live_q & ~full;
  assign wr_push     = i_s_valid & o_s_ready;
  assign wr_bin_nxt  = wr_bin_q + (PTR_W + 1)'(1);

  always_ff @(posedge clk_a) begin
    if (i_reset) begin
      wr_bin_q       <= '0;
      wr_gray_q      <= '0;
      rd_gray_sync_q <= '0;
      wr_live_q      <= 1'b0;
    end else begin
      wr_live_q      <= 1'b1;
      // read pointer into clk_a, oldest stage at the top
      rd_gray_sync_q <= {rd_gray_sync_q[SYNC_STAGES-2:0], rd_gray_q};
      if (wr_push) begin
        wr_bin_q  <= wr_bin_nxt;
        wr_gray_q <= bin2gray(wr_bin_nxt);
      end
    end
  end

  // the low pointer bits address the memory
  always_ff @(posedge clk_a) begin
    if (wr_push) begin
      mem[wr_bin_q[PTR_W-1:0]] <= i_s_data;
    end
  end

  // i_reset into clk_b, held until it has passed every stage
  always_ff @(posedge clk_b) begin
    rst_b_sync_q <= {rst_b_sync_q[SYNC_STAGES-2:0], i_reset};
  end

  assign rd_reset  = rst_b_sync_q[SYNC_STAGES-1];
  assign o_reset_b = rd_reset;

  // empty when the pointers match in full, wrap bit included
  assign empty      = (rd_gray_q == wr_gray_sync_q[SYNC_STAGES-1]);
  assign o_m_valid  = ~empty;
  assign rd_pop     = o_m_valid & i_m_ready;
  assign rd_bin_nxt = rd_bin_q + (PTR_W + 1)'(1);

  // fall through, the oldest word sits on the output
  assign o_m_data = mem[rd_bin_q[PTR_W-1:0]];

  always_ff @(posedge clk_b) begin
    if (rd_reset) begin
      rd_bin_q       <= '0;
      rd_gray_q      <= '0;
      wr_gray_sync_q <= '0;
    end else begin
      // write pointer into clk_b
      wr_gray_sync_q <= {wr_gray_sync_q[SYNC_STAGES-2:0], wr_gray_q};
      if (rd_pop) begin
        rd_bin_q  <= rd_bin_nxt;
        rd_gray_q <= bin2gray(rd_bin_nxt);
      end
    end
  end

endmodule : axis_async_fifo

`default_nettype wire

//--- rtl/axis_dw_pkg.sv
`default_nettype none

// width conversion between the wide FIFO word and the narrow master beat
package axis_dw_pkg;

  import axis_stream_pkg::*;

  // narrow beats per wide word
  localparam int RATIO = WIDTH_S / WIDTH_M;

  // beat counter width, kept at one bit or more
  localparam int BEAT_W = (RATIO > 1) ? $clog2(RATIO) : 1;

  // EMPTY  no word held, ready for a new one
  // SPLIT  a word held, beats still going out
  typedef enum logic {
    EMPTY,
    SPLIT
  } dw_state_t;

endpackage : axis_dw_pkg

`default_nettype wire

//--- rtl/axis_stream_pkg.sv
`default_nettype none

// stream widths and FIFO geometry for the clock and width converter
package axis_stream_pkg;

  // slave side word, written on clk_a
  localparam int WIDTH_S = 16;

  // master side beat, read on clk_b
  localparam int WIDTH_M = 8;

  // wide words held by the async FIFO
  // must stay a power of two for the gray pointers to wrap cleanly
  localparam int FIFO_DEPTH = 8;

  // memory address width
  // the pointers carry one extra bit on top of this for wrap detection
  localparam int PTR_W = $clog2(FIFO_DEPTH);

  // flops in each clock crossing synchronizer, two at least
  localparam int SYNC_STAGES = 2;

endpackage : axis_stream_pkg

`default_nettype wire
